// ==== vlog.f ====
+incdir+.
cur_buf_pkg.sv
cur_fetch_ctrl.sv
cur_block_store.sv
cur_row_handover.sv
cur_buffer.sv
tb_cur_buffer.sv

// ==== Bender.yml ====
package:
  name: cur_buffer

sources:
  - files:
      - cur_buf_pkg.sv
      - cur_fetch_ctrl.sv
      - cur_block_store.sv
      - cur_row_handover.sv
      - cur_buffer.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cur_buffer.sv

// ==== tb_cur_buffer_tasks.svh ====
// Included inside tb_cur_buffer; tasks change DUT inputs only on rising edges, check on falling
`ifndef TB_CUR_BUFFER_TASKS_SVH
`define TB_CUR_BUFFER_TASKS_SVH

// ----------------------------------------
// Helpers
// ----------------------------------------

task automatic check(input string name, input logic [BLOCK_W-1:0] actual,
                     input logic [BLOCK_W-1:0] expected);
    if (actual !== expected) begin
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        $display("Simulation failed");
        $fatal(1);
    end
endtask

// Pixel p at bits 8p, so row r covers bits 64r to 64r+63
task automatic build_image(output logic [BLOCK_W-1:0] img);
    logic [31:0] rnd;
    img = '0;
    for (int p = 0; p < BLOCK_DIM * BLOCK_DIM; p++) begin
        rnd = $random(seed);
        img[p * PIXEL_W +: PIXEL_W] = rnd[PIXEL_W-1:0];
    end
endtask

// Rows 0 to last_new from the new block, the rest from the old one
function automatic logic [BLOCK_W-1:0] mix_rows(input logic [BLOCK_W-1:0] new_img,
                                                input logic [BLOCK_W-1:0] old_img,
                                                input int last_new);
    logic [BLOCK_W-1:0] mixed;
    for (int r = 0; r < BLOCK_DIM; r++) begin
        if (r <= last_new) begin
            mixed[r * ROW_W +: ROW_W] = new_img[r * ROW_W +: ROW_W];
        end else begin
            mixed[r * ROW_W +: ROW_W] = old_img[r * ROW_W +: ROW_W];
        end
    end
    return mixed;
endfunction

// Returns just after the edge that samples the pulse
task automatic pulse_next_block(input int sel);
    img_sel = sel;
    @(posedge clk);
    next_block <= 1'b1;
    @(posedge clk);
    next_block <= 1'b0;
    @(negedge clk);
endtask

// Last word lands one edge after read_en falls
task automatic wait_fetch_done();
    while (read_en) begin
        @(negedge clk);
    end
    @(negedge clk);
endtask

// One more row per edge, then the whole new block
task automatic check_handover(input logic [BLOCK_W-1:0] new_img,
                              input logic [BLOCK_W-1:0] old_img);
    for (int s = 0; s < HANDOVER_STEPS; s++) begin
        @(negedge clk);
        check("cur_out", cur_out, mix_rows(new_img, old_img, s));
    end
    @(negedge clk);
    check("cur_out", cur_out, new_img);
endtask

task automatic check_hold(input logic held_read_en, input logic [ADDR_W-1:0] held_addr,
                          input logic [BLOCK_W-1:0] held_out);
    check("read_en", read_en, held_read_en);
    check("rd_addr", rd_addr, held_addr);
    check("cur_out", cur_out, held_out);
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------

task automatic reset_and_cold_boot();
    for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        if (i == 3) begin
            rst <= 1'b0;
        end
        @(negedge clk);
        check_hold(1'b0, '0, '0);
    end
    @(posedge clk);
    en <= 1'b1;
    @(negedge clk);
    check("read_en", read_en, 1'b0);
    // Cold boot fetches image A while the zeroed bank is shown
    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
        @(negedge clk);
        check_hold(1'b1, ADDR_W'(i), '0);
    end
    @(negedge clk);
    check("read_en", read_en, 1'b0);
    wait_fetch_done();
endtask

task automatic first_block();
    pulse_next_block(1);
    check_handover(images[0], '0);
    wait_fetch_done();
endtask

task automatic row_handover();
    pulse_next_block(2);
    check_handover(images[1], images[0]);
endtask

task automatic pingpong_isolation();
    // Image C fills the bank that just went out of use
    while (read_en) begin
        @(negedge clk);
        check("cur_out", cur_out, images[1]);
    end
    @(negedge clk);
    check("cur_out", cur_out, images[1]);
    pulse_next_block(3);
    check_handover(images[2], images[1]);
endtask

task automatic stall_and_resume();
    logic [BLOCK_W-1:0] held_out;

    // Stall in the middle of the fetch of image D, words 0 to 9 issued
    held_out = images[2];
    @(posedge clk);
    en <= 1'b0;
    for (int i = 0; i < 6; i++) begin
        @(negedge clk);
        check_hold(1'b1, ADDR_W'(9), held_out);
    end
    @(posedge clk);
    en <= 1'b1;
    @(negedge clk);
    check_hold(1'b1, ADDR_W'(9), held_out);
    wait_fetch_done();

    // Stall in the middle of the handover to image D
    pulse_next_block(4);
    for (int s = 0; s < 3; s++) begin
        @(negedge clk);
        check("cur_out", cur_out, mix_rows(images[3], images[2], s));
    end
    // Image E fetch has issued words 0 to 4 by then
    held_out = mix_rows(images[3], images[2], 3);
    @(posedge clk);
    en <= 1'b0;
    for (int i = 0; i < 5; i++) begin
        @(negedge clk);
        check_hold(1'b1, ADDR_W'(4), held_out);
    end
    @(posedge clk);
    en <= 1'b1;
    @(negedge clk);
    check_hold(1'b1, ADDR_W'(4), held_out);
    for (int s = 4; s < HANDOVER_STEPS; s++) begin
        @(negedge clk);
        check("cur_out", cur_out, mix_rows(images[3], images[2], s));
    end
    @(negedge clk);
    check("cur_out", cur_out, images[3]);
    wait_fetch_done();

    // Image E was fetched across the second stall
    pulse_next_block(0);
    check_handover(images[4], images[3]);
    wait_fetch_done();
endtask

`endif

// ==== tb_cur_buffer.sv ====
// Memory model answers each read one cycle later; the run stops at the first failed check
`timescale 1ns/1ps
`default_nettype none

module tb_cur_buffer;

    import cur_buf_pkg::*;

    // ----------------------------------------
    // Run limits and stimulus
    // ----------------------------------------

    // The directed tests fit well inside this budget
    localparam int TEST_CYCLES    = 400;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    localparam int NUM_IMAGES = 5;
    localparam int SEED_INIT  = 75646;

    logic               clk;
    logic               rst;
    logic               en;
    logic               next_block;
    logic [WORD_W-1:0]  cur_in;
    logic [BLOCK_W-1:0] cur_out;
    logic               read_en;
    logic [ADDR_W-1:0]  rd_addr;

    integer             seed;
    int                 cycle_count;

    // Block images served by the memory model, img_sel picks the one being fetched
    logic [BLOCK_W-1:0] images [NUM_IMAGES];
    int                 img_sel;

    `include "tb_cur_buffer_tasks.svh"

    cur_buffer i_cur_buffer (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .next_block (next_block),
        .cur_in     (cur_in),
        .cur_out    (cur_out),
        .read_en    (read_en),
        .rd_addr    (rd_addr)
    );

    // 10 ns period
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // ----------------------------------------
    // Memory model
    // ----------------------------------------

    // Word w of the image holds pixels 4w to 4w+3
    always @(posedge clk) begin
        if (read_en) begin
            cur_in <= images[img_sel][rd_addr * WORD_W +: WORD_W];
        end
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        seed       = SEED_INIT;
        img_sel    = 0;
        rst        = 1'b1;
        en         = 1'b0;
        next_block = 1'b0;
        cur_in     = '0;

        // Images A to E
        for (int i = 0; i < NUM_IMAGES; i++) begin
            build_image(images[i]);
        end

        reset_and_cold_boot();
        first_block();
        row_handover();
        pingpong_isolation();
        stall_and_resume();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cur_buffer.sv ====
// Memory gives each word the cycle after read_en; next_block needs 18 cycles after a block start
`timescale 1ns/1ps
`default_nettype none

module cur_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            en,
    input  logic                            next_block,
    input  logic [cur_buf_pkg::WORD_W-1:0]  cur_in,
    output logic [cur_buf_pkg::BLOCK_W-1:0] cur_out,
    output logic                            read_en,
    output logic [cur_buf_pkg::ADDR_W-1:0]  rd_addr
);

    import cur_buf_pkg::*;

    logic               block_start;
    logic               half;
    logic [BLOCK_W-1:0] bank0;
    logic [BLOCK_W-1:0] bank1;

    // ----------------------------------------
    // Fetch
    // ----------------------------------------

    cur_fetch_ctrl i_cur_fetch_ctrl (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .next_block  (next_block),
        .block_start (block_start),
        .read_en     (read_en),
        .rd_addr     (rd_addr)
    );

    // ----------------------------------------
    // Ping-pong banks
    // ----------------------------------------

    cur_block_store i_cur_block_store (
        .clk     (clk),
        .rst     (rst),
        .read_en (read_en),
        .rd_addr (rd_addr),
        .half    (half),
        .cur_in  (cur_in),
        .bank0   (bank0),
        .bank1   (bank1)
    );

    // ----------------------------------------
    // Output rows
    // ----------------------------------------

    cur_row_handover i_cur_row_handover (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .block_start (block_start),
        .bank0       (bank0),
        .bank1       (bank1),
        .half        (half),
        .cur_out     (cur_out)
    );

endmodule

`default_nettype wire

// ==== cur_row_handover.sv ====
// Handover takes 8 enabled cycles; a new block start during one restarts it from row 0
`timescale 1ns/1ps
`default_nettype none

module cur_row_handover (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            en,
    input  logic                            block_start,
    input  logic [cur_buf_pkg::BLOCK_W-1:0] bank0,
    input  logic [cur_buf_pkg::BLOCK_W-1:0] bank1,
    output logic                            half,
    output logic [cur_buf_pkg::BLOCK_W-1:0] cur_out
);

    import cur_buf_pkg::*;

    logic               in_handover;
    logic [STEP_W-1:0]  step;
    logic               last_step;

    // Bank that becomes current, and the one it replaces
    logic [BLOCK_W-1:0] new_bank;
    logic [BLOCK_W-1:0] old_bank;

    logic [BLOCK_W-1:0] next_out;

    // ----------------------------------------
    // Bank select and step counter
    // ----------------------------------------

    assign last_step = (step == STEP_W'(HANDOVER_STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            half        <= 1'b0;
            in_handover <= 1'b0;
            step        <= '0;
        end else if (en) begin
            if (block_start) begin
                half        <= ~half;
                in_handover <= 1'b1;
                step        <= '0;
            end else if (in_handover) begin
                if (last_step) begin
                    in_handover <= 1'b0;
                    step        <= '0;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // half high means bank 0 is current
    assign new_bank = half ? bank0 : bank1;
    assign old_bank = half ? bank1 : bank0;

    // ----------------------------------------
    // Row multiplexer
    // ----------------------------------------

    // Rows up to the current step already come from the new bank
    always_comb begin
        for (int r = 0; r < BLOCK_DIM; r++) begin
            if (!in_handover || (STEP_W'(r) <= step)) begin
                next_out[r * ROW_W +: ROW_W] = new_bank[r * ROW_W +: ROW_W];
            end else begin
                next_out[r * ROW_W +: ROW_W] = old_bank[r * ROW_W +: ROW_W];
            end
        end
    end

    // Held while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_out <= '0;
        end else if (en) begin
            cur_out <= next_out;
        end
    end

endmodule

`default_nettype wire

// ==== cur_block_store.sv ====
// half must stay stable until the last word of a fetch is written, 17 cycles after block start
`timescale 1ns/1ps
`default_nettype none

module cur_block_store (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            read_en,
    input  logic [cur_buf_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                            half,
    input  logic [cur_buf_pkg::WORD_W-1:0]  cur_in,
    output logic [cur_buf_pkg::BLOCK_W-1:0] bank0,
    output logic [cur_buf_pkg::BLOCK_W-1:0] bank1
);

    import cur_buf_pkg::*;

    // Read request delayed to line up with the returned word
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;

    // ----------------------------------------
    // Request delay
    // ----------------------------------------

    // Runs without en, so a stalled request rewrites the same word
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en   <= read_en;
            wr_addr <= rd_addr;
        end
    end

    // ----------------------------------------
    // Bank write
    // ----------------------------------------

    // half high: bank 1 fills
    // half low: bank 0 fills
    always_ff @(posedge clk) begin
        if (rst) begin
            bank0 <= '0;
            bank1 <= '0;
        end else if (wr_en) begin
            if (half) begin
                bank1[wr_addr * WORD_W +: WORD_W] <= cur_in;
            end else begin
                bank0[wr_addr * WORD_W +: WORD_W] <= cur_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cur_fetch_ctrl.sv ====
// Memory must answer read_en one cycle later without back-pressure; next_block restarts a fetch
`timescale 1ns/1ps
`default_nettype none

module cur_fetch_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  logic                           next_block,
    output logic                           block_start,
    output logic                           read_en,
    output logic [cur_buf_pkg::ADDR_W-1:0] rd_addr
);

    import cur_buf_pkg::*;

    // Set until the first block has been started
    logic cold_boot;

    logic last_word;

    // ----------------------------------------
    // Block start
    // ----------------------------------------

    // First enabled cycle after reset starts a block on its own
    assign block_start = en && (next_block || cold_boot);

    always_ff @(posedge clk) begin
        if (rst) begin
            cold_boot <= 1'b1;
        end else if (block_start) begin
            cold_boot <= 1'b0;
        end
    end

    // ----------------------------------------
    // Word read sequence
    // ----------------------------------------

    assign last_word = (rd_addr == ADDR_W'(WORDS_PER_BLOCK - 1));

    // Address stays on the last word once the fetch is done
    always_ff @(posedge clk) begin
        if (rst) begin
            read_en <= 1'b0;
            rd_addr <= '0;
        end else if (block_start) begin
            read_en <= 1'b1;
            rd_addr <= '0;
        end else if (en && read_en) begin
            if (last_word) begin
                read_en <= 1'b0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cur_buf_pkg.sv ====
// Sizes assume an 8x8 block of 8-bit pixels fetched as 32-bit words; other sizes are untested
`default_nettype none

package cur_buf_pkg;

    // ----------------------------------------
    // Pixel and block geometry
    // ----------------------------------------

    // Bits per pixel
    localparam int PIXEL_W = 8;

    // Pixels per row, and rows per block
    localparam int BLOCK_DIM = 8;

    // One block row, lowest pixel in the lowest bits
    localparam int ROW_W = BLOCK_DIM * PIXEL_W;

    // Whole block, row 0 in the lowest bits
    localparam int BLOCK_W = BLOCK_DIM * ROW_W;

    // ----------------------------------------
    // Memory side
    // ----------------------------------------

    // Memory word, four pixels
    localparam int WORD_W = 4 * PIXEL_W;

    localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;
    localparam int WORDS_PER_ROW   = ROW_W / WORD_W;

    // Word address inside one block
    localparam int ADDR_W = $clog2(WORDS_PER_BLOCK);

    // ----------------------------------------
    // Row handover
    // ----------------------------------------

    // One step per row, the last row comes with the swap itself
    localparam int STEP_W         = $clog2(BLOCK_DIM);
    localparam int HANDOVER_STEPS = BLOCK_DIM - 1;

endpackage

`default_nettype wire
